// File: verilog/spi_pkg.sv
package spi_pkg;

	// Host side widths
	localparam int DATA_W  = 32;
	localparam int CMD_W   = 8;
	localparam int ADDR_W  = 24;
	localparam int CTYP_W  = 3;
	localparam int NBITS_W = 6;  // Data bit count from 0 to 32
	localparam int DUMMY_W = 4;

	// Frame side widths
	localparam int EDGE_W  = 8;  // Up to 158 SCLK edges
	localparam int FRAME_W = 64; // Command, address and data
	localparam int CNT_W   = 7;  // Frame bit counters and positions

	// Command types where 6 and 7 behave as CT_CMD
	localparam logic [CTYP_W-1:0] CT_CMD         = 3'd0;
	localparam logic [CTYP_W-1:0] CT_CMD_RD      = 3'd1;
	localparam logic [CTYP_W-1:0] CT_CMD_ADDR_RD = 3'd2;
	localparam logic [CTYP_W-1:0] CT_CMD_WR      = 3'd3;
	localparam logic [CTYP_W-1:0] CT_CMD_ADDR_WR = 3'd4;
	localparam logic [CTYP_W-1:0] CT_CMD_ADDR    = 3'd5;

	// Fixed frame lengths in bits
	localparam logic [CNT_W-1:0] LEN_CMD      = CNT_W'(CMD_W);
	localparam logic [CNT_W-1:0] LEN_CMD_ADDR = CNT_W'(CMD_W + ADDR_W);

endpackage

// File: verilog/spi_frame_if.sv
`timescale 1ns/10ps

interface spi_frame_if import spi_pkg::*; ();

	logic [FRAME_W-1:0] tx_str;     // MOSI string, MSB first
	logic [CNT_W-1:0]   tx_bits;    // Bits to send on MOSI
	logic [NBITS_W-1:0] rx_bits;    // Bits to sample from MISO
	logic [CNT_W-1:0]   rx_start;   // Period index of first read bit
	logic [EDGE_W-1:0]  sclk_edges;
	logic               frame_ready;

	modport builder (
		output tx_str, tx_bits, rx_bits, rx_start, sclk_edges, frame_ready
	);

	modport consumer (
		input tx_str, tx_bits, rx_bits, rx_start, sclk_edges, frame_ready
	);

endinterface

// File: verilog/spi_sclk_gen.sv
`timescale 1ns/10ps

module spi_sclk_gen import spi_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL = 0,
	parameter int CPHA = 0
) (
	input  logic rst,
	input  logic clk,
	input  logic op_start,
	input  logic sclk_en,
	spi_frame_if.consumer frame,
	output logic sclk,
	output logic latch_in,
	output logic latch_out,
	output logic op_done
);

	localparam int DIV_W = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
	localparam logic IDLE_LVL = 1'(CPOL);

	logic [DIV_W-1:0]  div_cnt;
	logic [EDGE_W-1:0] edges_left;
	logic              running;
	logic              half_tick;
	logic              lead_edge;
	logic              trail_edge;

	assign running    = sclk_en && (edges_left != '0);
	assign half_tick  = running && (div_cnt == DIV_W'(CLKS_PER_HALF_SCLK - 1));
	assign lead_edge  = half_tick && (sclk == IDLE_LVL);  // Leaving idle level
	assign trail_edge = half_tick && (sclk != IDLE_LVL);

	// Sample on leading edge for CPHA 0, shift on the other one
	assign latch_in  = (CPHA != 0) ? trail_edge : lead_edge;
	assign latch_out = (CPHA != 0) ? lead_edge : trail_edge;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			sclk       <= IDLE_LVL;
			div_cnt    <= '0;
			edges_left <= '0;
			op_done    <= 1'b0;
		end else begin
			op_done <= 1'b0;
			if (op_start) begin
				edges_left <= frame.sclk_edges;
				div_cnt    <= '0;
				sclk       <= IDLE_LVL;
			end else if (half_tick) begin
				div_cnt    <= '0;
				sclk       <= ~sclk;
				edges_left <= edges_left - 1'b1;
				op_done    <= (edges_left == EDGE_W'(1)); // Last edge of the frame
			end else if (running) begin
				div_cnt <= div_cnt + 1'b1;
			end else if (!sclk_en) begin
				sclk <= IDLE_LVL;
			end
		end
	end

	// Clock must rest at its idle level whenever the controller is not transferring
	a_sclk_idle: assert property (@(posedge rst) disable iff (clk)
		!sclk_en |-> sclk == IDLE_LVL)
		else $error("sclk left idle level while sclk_en low");

endmodule

// File: verilog/spi_frame_setup.sv
`timescale 1ns/10ps

module spi_frame_setup import spi_pkg::*; (
	input  logic               rst,
	input  logic               clk,
	input  logic               load,
	input  logic [CTYP_W-1:0]  cmd_type,
	input  logic [CMD_W-1:0]   command,
	input  logic [ADDR_W-1:0]  address,
	input  logic [DATA_W-1:0]  data_in,
	input  logic [NBITS_W-1:0] nbits,
	input  logic [DUMMY_W-1:0] dummy_cycles,
	spi_frame_if.builder       frame
);

	// Request as sampled on acceptance
	logic [CTYP_W-1:0]  r_type;
	logic [CMD_W-1:0]   r_cmd;
	logic [ADDR_W-1:0]  r_addr;
	logic [DATA_W-1:0]  r_data;
	logic [NBITS_W-1:0] r_nbits;
	logic [DUMMY_W-1:0] r_dummy;
	logic               r_build;

	logic [FRAME_W-1:0] tx_str_c;
	logic [CNT_W-1:0]   tx_bits_c;
	logic [NBITS_W-1:0] rx_bits_c;
	logic [CNT_W-1:0]   dummy_c;
	logic [CNT_W-1:0]   rx_start_c;
	logic [CNT_W-1:0]   periods_c;

	always_ff @(posedge rst) begin
		if (load) begin
			r_type  <= cmd_type;
			r_cmd   <= command;
			r_addr  <= address;
			r_data  <= data_in;
			r_nbits <= nbits;
			r_dummy <= dummy_cycles;
		end
	end

	always_comb begin
		tx_str_c  = {r_cmd, {(FRAME_W - CMD_W){1'b0}}};
		tx_bits_c = LEN_CMD;
		rx_bits_c = '0;
		dummy_c   = '0;
		case (r_type)
			CT_CMD_RD: rx_bits_c = r_nbits;
			CT_CMD_ADDR_RD: begin
				tx_str_c  = {r_cmd, r_addr, {DATA_W{1'b0}}};
				tx_bits_c = LEN_CMD_ADDR;
				rx_bits_c = r_nbits;
				dummy_c   = CNT_W'(r_dummy); // Only this type waits before reading
			end
			CT_CMD_WR: begin
				tx_str_c  = {r_cmd, r_data, {ADDR_W{1'b0}}};
				tx_bits_c = LEN_CMD + CNT_W'(r_nbits);
			end
			CT_CMD_ADDR_WR: begin
				tx_str_c  = {r_cmd, r_addr, r_data};
				tx_bits_c = LEN_CMD_ADDR + CNT_W'(r_nbits);
			end
			CT_CMD_ADDR: begin
				tx_str_c  = {r_cmd, r_addr, {DATA_W{1'b0}}};
				tx_bits_c = LEN_CMD_ADDR;
			end
			default: ; // Command only
		endcase
		rx_start_c = tx_bits_c + dummy_c;
		periods_c  = rx_start_c + CNT_W'(rx_bits_c);
	end

	// Build cycle one clock after load
	always_ff @(posedge rst) begin
		if (r_build) begin
			frame.tx_str     <= tx_str_c;
			frame.tx_bits    <= tx_bits_c;
			frame.rx_bits    <= rx_bits_c;
			frame.rx_start   <= rx_start_c;
			frame.sclk_edges <= EDGE_W'({periods_c, 1'b0}); // Two edges per period
		end
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			r_build           <= 1'b0;
			frame.frame_ready <= 1'b0;
		end else begin
			r_build           <= load;
			frame.frame_ready <= r_build;
		end
	end

endmodule

// File: verilog/spi_shifter.sv
`timescale 1ns/10ps

module spi_shifter import spi_pkg::*; #(
	parameter int CPHA = 0
) (
	input  logic              rst,
	input  logic              clk,
	input  logic              op_start,
	input  logic              latch_in,
	input  logic              latch_out,
	spi_frame_if.consumer     frame,
	input  logic              miso,
	output logic              mosi,
	output logic [DATA_W-1:0] read_word
);

	logic [FRAME_W-1:0] sh;       // Bits still to go out
	logic [CNT_W-1:0]   out_cnt;  // Bits presented on MOSI
	logic [CNT_W-1:0]   bit_cnt;  // SCLK periods sampled so far
	logic [CNT_W-1:0]   rx_end;
	logic               in_window;
	logic               more_tx;

	assign rx_end    = frame.rx_start + CNT_W'(frame.rx_bits);
	assign in_window = (bit_cnt >= frame.rx_start) && (bit_cnt < rx_end);
	assign more_tx   = out_cnt < frame.tx_bits;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			mosi    <= 1'b0;
			out_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			if (op_start) begin
				bit_cnt <= '0;
				if (CPHA == 0) begin
					mosi    <= frame.tx_str[FRAME_W-1]; // First bit ahead of the first edge
					out_cnt <= CNT_W'(1);
				end else begin
					mosi    <= 1'b0;
					out_cnt <= '0;
				end
			end else begin
				if (latch_out) begin
					mosi <= more_tx ? sh[FRAME_W-1] : 1'b0;
					if (more_tx)
						out_cnt <= out_cnt + 1'b1;
				end
				if (latch_in)
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge rst) begin
		if (op_start) begin
			sh        <= (CPHA == 0) ? {frame.tx_str[FRAME_W-2:0], 1'b0} : frame.tx_str;
			read_word <= '0;
		end else begin
			if (latch_out && more_tx)
				sh <= {sh[FRAME_W-2:0], 1'b0};
			if (latch_in && in_window)
				read_word <= {read_word[DATA_W-2:0], miso}; // Right aligned
		end
	end

	// Edge count from the clock generator must match the frame length
	a_bit_window: assert property (@(posedge rst) disable iff (clk)
		latch_in |-> bit_cnt < rx_end)
		else $error("sample edge beyond end of frame");

endmodule

// File: verilog/spi_master_ctrl.sv
`timescale 1ns/10ps

module spi_master_ctrl import spi_pkg::*; (
	input  logic              rst,
	input  logic              clk,
	input  logic              valid,
	output logic              ready,
	output logic              load,
	input  logic              frame_ready,
	output logic              op_start,
	output logic              sclk_en,
	input  logic              op_done,
	input  logic [DATA_W-1:0] read_word,
	output logic [DATA_W-1:0] data_out,
	output logic              ss_n
);

	localparam logic [1:0] S_IDLE     = 2'd0;
	localparam logic [1:0] S_SETUP    = 2'd1;
	localparam logic [1:0] S_TRANSFER = 2'd2;

	logic [1:0] state;

	// Accept strobe that samples the inputs
	assign load = ready && valid;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state    <= S_IDLE;
			ready    <= 1'b1;
			op_start <= 1'b0;
			sclk_en  <= 1'b0;
			ss_n     <= 1'b1;
			data_out <= '0;
		end else begin
			op_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (load) begin
						ready <= 1'b0;
						state <= S_SETUP;
					end
				end
				S_SETUP: begin
					if (frame_ready) begin
						op_start <= 1'b1;
						sclk_en  <= 1'b1;
						ss_n     <= 1'b0; // Select the flash
						state    <= S_TRANSFER;
					end
				end
				S_TRANSFER: begin
					if (op_done) begin
						sclk_en  <= 1'b0;
						ss_n     <= 1'b1;
						ready    <= 1'b1;
						data_out <= read_word;
						state    <= S_IDLE;
					end
				end
				default: begin
					sclk_en <= 1'b0;
					ss_n    <= 1'b1;
					ready   <= 1'b1;
					state   <= S_IDLE;
				end
			endcase
		end
	end

	// Host must never see ready while the flash is selected
	a_ss_ready: assert property (@(posedge rst) disable iff (clk)
		!ss_n |-> !ready)
		else $error("ready high while ss_n low");

	a_start_setup: assert property (@(posedge rst) disable iff (clk)
		op_start |-> $past(state == S_SETUP))
		else $error("op_start not issued from SETUP");

endmodule

// File: verilog/spi_master.sv
`timescale 1ns/10ps

module spi_master import spi_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL = 0,
	parameter int CPHA = 0
) (
	input  logic               rst,
	input  logic               clk,
	input  logic               valid,
	output logic               ready,
	input  logic [CTYP_W-1:0]  cmd_type,
	input  logic [CMD_W-1:0]   command,
	input  logic [ADDR_W-1:0]  address,
	input  logic [DATA_W-1:0]  data_in,
	input  logic [NBITS_W-1:0] nbits,
	input  logic [DUMMY_W-1:0] dummy_cycles,
	output logic [DATA_W-1:0]  data_out,
	output logic               sclk,
	output logic               ss_n,
	output logic               mosi,
	input  logic               miso
);

	logic              load;
	logic              op_start;
	logic              sclk_en;
	logic              op_done;
	logic              latch_in;
	logic              latch_out;
	logic [DATA_W-1:0] read_word;

	spi_frame_if u_frame ();

	spi_master_ctrl u_ctrl (
		.rst(rst), .clk(clk),
		.valid(valid), .ready(ready), .load(load),
		.frame_ready(u_frame.frame_ready),
		.op_start(op_start), .sclk_en(sclk_en), .op_done(op_done),
		.read_word(read_word), .data_out(data_out), .ss_n(ss_n)
	);

	spi_frame_setup u_setup (
		.rst(rst), .clk(clk), .load(load),
		.cmd_type(cmd_type), .command(command), .address(address),
		.data_in(data_in), .nbits(nbits), .dummy_cycles(dummy_cycles),
		.frame(u_frame.builder)
	);

	spi_sclk_gen #(
		.CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK), .CPOL(CPOL), .CPHA(CPHA)
	) u_sclk_gen (
		.rst(rst), .clk(clk),
		.op_start(op_start), .sclk_en(sclk_en), .frame(u_frame.consumer),
		.sclk(sclk), .latch_in(latch_in), .latch_out(latch_out), .op_done(op_done)
	);

	spi_shifter #(.CPHA(CPHA)) u_shifter (
		.rst(rst), .clk(clk),
		.op_start(op_start), .latch_in(latch_in), .latch_out(latch_out),
		.frame(u_frame.consumer), .miso(miso),
		.mosi(mosi), .read_word(read_word)
	);

endmodule

// File: tb/spi_flash_model.sv
`timescale 1ns/10ps

module spi_flash_model (
	input  logic         sclk,
	input  logic         ss_n,
	input  logic         mosi,
	output logic         miso,
	output logic [7:0]   periods,    // SCLK periods seen in the last frame
	output logic [127:0] mosi_bits   // MOSI bits of the last frame, last one at bit 0
);

	logic [7:0] first_byte;
	logic [2:0] pos;

	initial begin
		miso       = 1'b0;
		periods    = '0;
		mosi_bits  = '0;
		first_byte = '0;
		pos        = '0;
		forever begin
			@(negedge ss_n);
			periods    = '0;
			mosi_bits  = '0;
			first_byte = '0;
			while (!ss_n) begin
				@(posedge sclk or negedge sclk or posedge ss_n);
				if (!ss_n && sclk) begin
					mosi_bits = {mosi_bits[126:0], mosi};
					if (periods < 8'd8)
						first_byte = {first_byte[6:0], mosi}; // Command byte
					periods = periods + 8'd1;
				end else if (!ss_n && !sclk) begin
					// Inverted command bit for the next period
					pos  = 3'd7 - periods[2:0];
					miso = ~first_byte[pos];
				end
			end
		end
	end

endmodule

// File: tb/tb_spi_master.sv
`timescale 1ns/10ps

module tb_spi_master import spi_pkg::*; ();

	localparam int N_REQ      = 40;
	localparam int MAX_CYCLES = N_REQ * 200; // Longest frame is 79 periods, most are far shorter

	logic               rst;  // System clock
	logic               clk;  // Reset, active high
	logic               valid;
	logic               ready;
	logic [CTYP_W-1:0]  cmd_type;
	logic [CMD_W-1:0]   command;
	logic [ADDR_W-1:0]  address;
	logic [DATA_W-1:0]  data_in;
	logic [NBITS_W-1:0] nbits;
	logic [DUMMY_W-1:0] dummy_cycles;
	logic [DATA_W-1:0]  data_out;
	logic               sclk;
	logic               ss_n;
	logic               mosi;
	logic               miso;
	logic [7:0]         flash_periods;
	logic [127:0]       flash_bits;
	integer             seed;
	int                 cycles;

	spi_master u_spi_master (
		.rst(rst), .clk(clk), .valid(valid), .ready(ready),
		.cmd_type(cmd_type), .command(command), .address(address),
		.data_in(data_in), .nbits(nbits), .dummy_cycles(dummy_cycles),
		.data_out(data_out), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso)
	);

	spi_flash_model u_flash (
		.sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
		.periods(flash_periods), .mosi_bits(flash_bits)
	);

	initial begin
		rst = 1'b0;
		forever #20 rst = ~rst;
	end

	initial cycles = 0;

	always @(posedge rst) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: no end of test after %0d clock cycles", MAX_CYCLES);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	// Flash selected only while the master is busy
	a_sel_busy: assert property (@(posedge rst) disable iff (clk) !(!ss_n && ready))
		else begin
			$display("Slave select is low while ready is high");
			$display("TB FAILED");
			$fatal(1);
		end

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] got);
		assert (got === expected) else begin
			$display("Error %s: expected %0h, received %0h", name, expected, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// Expected MOSI stream, period count and read window of one request
	task automatic build_expected(input logic [CTYP_W-1:0] t, input logic [CMD_W-1:0] c,
		input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
		input logic [NBITS_W-1:0] nb, input logic [DUMMY_W-1:0] dm,
		output logic [127:0] stream, output int n_periods, output int rd_start,
		output int rd_len);
		int tx_len;
		int wr_len;
		int wait_len;
		logic [127:0] wr_bits;
		stream   = 128'(c);
		tx_len   = CMD_W;
		wait_len = 0;
		rd_len   = 0;
		wr_len   = int'(nb);
		wr_bits  = 128'(d >> (DATA_W - wr_len)); // Top nbits of the data word
		case (t)
			CT_CMD_RD: rd_len = int'(nb);
			CT_CMD_ADDR_RD: begin
				stream   = (stream << ADDR_W) | 128'(a);
				tx_len   = tx_len + ADDR_W;
				wait_len = int'(dm);
				rd_len   = int'(nb);
			end
			CT_CMD_WR: begin
				stream = (stream << wr_len) | wr_bits;
				tx_len = tx_len + wr_len;
			end
			CT_CMD_ADDR_WR: begin
				stream = (((stream << ADDR_W) | 128'(a)) << wr_len) | wr_bits;
				tx_len = tx_len + ADDR_W + wr_len;
			end
			CT_CMD_ADDR: begin
				stream = (stream << ADDR_W) | 128'(a);
				tx_len = tx_len + ADDR_W;
			end
			default: ;
		endcase
		rd_start  = tx_len + wait_len;
		n_periods = rd_start + rd_len;
		stream    = stream << (n_periods - tx_len); // MOSI low after the sent bits
	endtask

	task automatic run_request(input int idx);
		logic [127:0]      exp_stream;
		logic [DATA_W-1:0] exp_word;
		int                n_periods;
		int                rd_start;
		int                rd_len;
		int                k;
		@(posedge rst);
		#2;
		cmd_type     = CTYP_W'(idx % 8); // 6 and 7 act as command only
		command      = CMD_W'($random(seed));
		address      = ADDR_W'($random(seed));
		data_in      = DATA_W'($random(seed));
		nbits        = NBITS_W'(1 + ($unsigned($random(seed)) % 32));
		dummy_cycles = DUMMY_W'($random(seed));
		valid        = 1'b1;
		build_expected(cmd_type, command, address, data_in, nbits, dummy_cycles,
			exp_stream, n_periods, rd_start, rd_len);
		exp_word = '0;
		for (k = rd_start; k < rd_start + rd_len; k++)
			exp_word = {exp_word[DATA_W-2:0], ~command[3'(7 - (k % 8))]};
		@(posedge rst); // Accepted on this edge with ready high
		#2;
		valid = 1'b0;
		@(posedge rst);
		#1;
		check_value("ss_n", 128'(1'b1), 128'(ss_n));
		@(posedge rst);
		#1;
		check_value("ss_n", 128'(1'b0), 128'(ss_n));
		while (!ready) begin
			@(posedge rst);
			#1;
		end
		check_value("ss_n", 128'(1'b1), 128'(ss_n));
		check_value("mosi", exp_stream, flash_bits);
		check_value("sclk periods", 128'(n_periods), 128'(flash_periods));
		check_value("data_out", 128'(exp_word), 128'(data_out));
	endtask

	initial begin
		seed         = 32'h62de;
		clk          = 1'b1;
		valid        = 1'b0;
		cmd_type     = '0;
		command      = '0;
		address      = '0;
		data_in      = '0;
		nbits        = '0;
		dummy_cycles = '0;
		repeat (16) @(posedge rst);
		#2;
		clk = 1'b0;
		@(posedge rst);
		#1;
		check_value("ready", 128'(1'b1), 128'(ready));
		check_value("ss_n", 128'(1'b1), 128'(ss_n));
		check_value("sclk", 128'(1'b0), 128'(sclk));
		check_value("data_out", 128'(0), 128'(data_out));
		for (int i = 0; i < N_REQ; i++)
			run_request(i);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verilog.f
verilog/spi_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_sclk_gen.sv
verilog/spi_frame_setup.sv
verilog/spi_shifter.sv
verilog/spi_master_ctrl.sv
verilog/spi_master.sv
tb/spi_flash_model.sv
tb/tb_spi_master.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing
TOP       = tb_spi_master
FILE_LIST = verilog.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
